//--- sources.f
hdl/isp_pkg.sv
hdl/line_store.sv
hdl/bayer_interp.sv
hdl/isp_csr.sv
hdl/rgb_out_stage.sv
hdl/debayer_top.sv
dv/debayer_assert.sv
dv/debayer_checker.sv
dv/debayer_tb.sv

//--- Makefile
SIM := obj_dir/Vdebayer_tb
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert --top-module debayer_tb -f sources.f

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- dv/debayer_tb.sv
// Simulation top that drives random frames and register writes into the de-Bayer DUT and scoreboard
module debayer_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import isp_pkg::*;

   localparam int LINE_LENGTH = 16;
   localparam int NUM_LINES   = 22;
   localparam int NUM_WRITES  = 6;
   localparam int EXP_ROWS    = 17;   // Lines 3..14 and 17..21

   logic       clk = 1'b0;
   logic       rst;
   pix_word_t  pix_in;
   logic       pix_valid;
   logic       csr_we;
   logic [1:0] csr_addr;
   logic [7:0] csr_wdata;
   logic [7:0] csr_rdata;
   rgb_t       rgb_out;
   logic       rgb_valid;
   logic [2:0] test_id;

   int gaps [NUM_LINES];
   int limit;
   int cycles;
   int tb_errors;
   int pix_errors, csr_errors, other_errors, pending, rows;

   always #2 clk = ~clk;   // 4 ns period

   debayer_top #(.LINE_LENGTH(LINE_LENGTH)) uut (
      .clk, .rst,
      .pix_in, .pix_valid,
      .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
      .rgb_out, .rgb_valid
   );

   debayer_checker #(.LINE_LENGTH(LINE_LENGTH)) chk (
      .clk, .rst,
      .pix_in, .pix_valid,
      .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
      .rgb_out, .rgb_valid, .test_id,
      .pix_errors, .csr_errors, .other_errors, .pending, .rows
   );

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // One line of random words, optional CTRL write in the middle, then the gap
   task automatic send_line(input int n, input logic wr_mid, input logic [7:0] wdata);
      for (int i = 0; i < LINE_LENGTH; i++) begin
         @(posedge clk);
         pix_valid <= 1'b1;
         pix_in    <= pix_word_t'(16'($urandom));
         if (wr_mid && i == 8) begin
            csr_we    <= 1'b1;
            csr_addr  <= CSR_CTRL;
            csr_wdata <= wdata;
         end else begin
            csr_we   <= 1'b0;
            csr_addr <= CSR_ROWS;
         end
      end
      @(posedge clk);
      pix_valid <= 1'b0;
      repeat (gaps[n] - 1) @(posedge clk);
   endtask

   // Single-cycle write, then hold the address for readback
   task automatic csr_write(input logic [1:0] addr, input logic [7:0] data);
      @(posedge clk);
      csr_we    <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      @(posedge clk);
      csr_we <= 1'b0;
      repeat (3) @(posedge clk);
      csr_addr <= CSR_ROWS;
   endtask

   initial begin
      int total;
      rst       = 1'b1;
      pix_in    = '0;
      pix_valid = 1'b0;
      csr_we    = 1'b0;
      csr_addr  = CSR_ROWS;
      csr_wdata = 8'd0;
      test_id   = 3'd0;
      cycles    = 0;
      limit     = 0;
      tb_errors = 0;
      void'($urandom(22926));
      total = 0;
      for (int i = 0; i < NUM_LINES; i++) begin
         gaps[i] = 24 + int'($urandom % 17);   // 24..40 idle cycles
         total   = total + LINE_LENGTH + gaps[i];
      end
      limit = total + 6 * NUM_WRITES + 20 + 200;

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      for (int n = 0; n < 8; n++) send_line(n, 1'b0, 8'd0);
      csr_write(CSR_INVERT, 8'h00);
      test_id <= 3'd1;
      for (int n = 8; n < 10; n++) send_line(n, 1'b0, 8'd0);
      csr_write(CSR_INVERT, 8'h07);
      test_id <= 3'd2;
      for (int n = 10; n < 12; n++) send_line(n, 1'b0, 8'd0);
      csr_write(CSR_CTRL, 8'h03);   // Bars on
      test_id <= 3'd3;
      for (int n = 12; n < 14; n++) send_line(n, 1'b0, 8'd0);
      csr_write(CSR_CTRL, 8'h01);
      csr_write(CSR_INVERT, {5'd0, INVERT_RESET});
      test_id <= 3'd4;
      send_line(14, 1'b1, 8'h00);   // Disable while this row runs
      for (int n = 15; n < 17; n++) send_line(n, 1'b0, 8'd0);
      csr_write(CSR_CTRL, 8'h01);
      for (int n = 17; n < NUM_LINES; n++) send_line(n, 1'b0, 8'd0);
      repeat (10) @(posedge clk);

      if (rows != EXP_ROWS) begin
         $display("ERROR row_count: expected %0d actual %0d", EXP_ROWS, rows);
         tb_errors++;
      end
      $display("Errors: pixel %0d, csr %0d, other %0d, testbench %0d, pixels pending %0d",
               pix_errors, csr_errors, other_errors, tb_errors, pending);
      if (pix_errors + csr_errors + other_errors + tb_errors == 0 && pending == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- dv/debayer_checker.sv
// Scoreboard of the de-Bayer path: models line buffering and interpolation, compares every pixel
module debayer_checker #(
   parameter int LINE_LENGTH = 16
) (
   input  logic               clk,
   input  logic               rst,
   input  isp_pkg::pix_word_t pix_in,
   input  logic               pix_valid,
   input  logic               csr_we,
   input  logic [1:0]         csr_addr,
   input  logic [7:0]         csr_wdata,
   input  logic [7:0]         csr_rdata,
   input  isp_pkg::rgb_t      rgb_out,
   input  logic               rgb_valid,
   input  logic [2:0]         test_id,     // Current test phase
   output int                 pix_errors,
   output int                 csr_errors,
   output int                 other_errors,
   output int                 pending,     // Expected pixels not yet seen
   output int                 rows         // Rows fully received
);
   timeunit 1ns;
   timeprecision 100ps;
   import isp_pkg::*;

   pix_word_t  mem [4][LINE_LENGTH];   // Model line store
   int         line_cnt;
   int         word_cnt;
   int         row_pix;                // Pixels received in the current row
   logic       pv_q;
   logic       m_enable;               // Model of the control register
   logic       m_bars;
   logic [2:0] m_invert;
   rgb_t       exp_q [$];

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd0:    return "default_invert";
         3'd1:    return "invert_zero";
         3'd2:    return "invert_ones";
         3'd3:    return "color_bars";
         3'd4:    return "enable_toggle";
         default: return "unknown";
      endcase
   endfunction

   // Each term halved or quartered before the sum
   function automatic logic [7:0] half_of(input logic [7:0] x, input logic [7:0] y);
      int s;
      s = int'(x) / 2 + int'(y) / 2;
      return 8'(s);
   endfunction

   function automatic logic [7:0] quarter_of(input logic [7:0] p, input logic [7:0] q,
                                             input logic [7:0] r, input logic [7:0] s);
      int t;
      t = int'(p) / 4 + int'(q) / 4 + int'(r) / 4 + int'(s) / 4;
      return 8'(t);
   endfunction

   //------------------------------------------------------------
   // Expected row for input line k
   //------------------------------------------------------------

   task automatic queue_row(input int k);
      int         up;
      int         cen;
      int         dn;
      int         w;
      int         wn;
      logic [2:0] bar;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      pix_word_t  ua, ub, ca, cb, da, db;
      rgb_t       px;
      up  = (k - 3) % 4;
      cen = (k - 2) % 4;
      dn  = (k - 1) % 4;
      for (int col = 0; col < 2 * LINE_LENGTH; col++) begin
         w  = col / 2;
         wn = (w == LINE_LENGTH - 1) ? w : w + 1;   // Clamp at right edge
         ua = mem[up][w];
         ub = mem[up][wn];
         ca = mem[cen][w];
         cb = mem[cen][wn];
         da = mem[dn][w];
         db = mem[dn][wn];
         if ((k - 2) % 2 == 1) begin   // R G center
            if (col % 2 == 0) begin
               r = ca.first;
               g = quarter_of(ub.first, ca.second, cb.second, db.first);
               b = quarter_of(ua.second, ub.second, da.second, db.second);
            end else begin
               r = half_of(ca.first, cb.first);
               g = ca.second;
               b = half_of(ua.second, da.second);
            end
         end else begin                // G B center
            if (col % 2 == 0) begin
               r = half_of(ua.first, da.first);
               g = ca.first;
               b = half_of(ca.second, cb.second);
            end else begin
               r = quarter_of(ua.first, ub.first, da.first, db.first);
               g = quarter_of(ca.first, cb.first, ua.second, da.second);
               b = ca.second;
            end
         end
         if (m_bars) begin
            bar = 3'(col * 8 / (2 * LINE_LENGTH));
            r   = bar[2] ? 8'hff : 8'h00;
            g   = bar[1] ? 8'hff : 8'h00;
            b   = bar[0] ? 8'hff : 8'h00;
         end
         if (m_invert[2]) r = ~r;   // Inversion after bars
         if (m_invert[1]) g = ~g;
         if (m_invert[0]) b = ~b;
         px.red   = r;
         px.green = g;
         px.blue  = b;
         exp_q.push_back(px);
      end
   endtask

   //------------------------------------------------------------
   // Per-cycle watch
   //------------------------------------------------------------

   always @(posedge clk) begin : watch
      rgb_t       expv;
      logic [7:0] exp_rd;
      if (rst) begin
         line_cnt = 0;
         word_cnt = 0;
         row_pix  = 0;
         pv_q     = 1'b0;
         m_enable = 1'b1;
         m_bars   = 1'b0;
         m_invert = INVERT_RESET;
         exp_q.delete();
         pix_errors   = 0;
         csr_errors   = 0;
         other_errors = 0;
         rows         = 0;
      end else begin
         // Output side first, model state as of this edge
         if (rgb_valid) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected output pixel in %s, no row was due", test_name(test_id));
               other_errors++;
            end else begin
               expv = exp_q.pop_front();
               if (rgb_out !== expv) begin
                  $display("ERROR %s: expected %h actual %h (row %0d pixel %0d)",
                           test_name(test_id), expv, rgb_out, rows, row_pix);
                  pix_errors++;
               end
            end
            row_pix++;
            if (row_pix == 2 * LINE_LENGTH) begin
               rows++;
               row_pix = 0;
            end
         end else begin
            if (row_pix != 0) begin
               $display("Output row stopped after %0d pixels", row_pix);
               other_errors++;
               row_pix = 0;
            end
            if (!csr_we) begin   // Readback only while no row is in flight
               case (csr_addr)
                  CSR_CTRL:   exp_rd = {6'd0, m_bars, m_enable};
                  CSR_INVERT: exp_rd = {5'd0, m_invert};
                  CSR_ROWS:   exp_rd = 8'(rows);
                  default:    exp_rd = 8'd0;
               endcase
               if (csr_rdata !== exp_rd) begin
                  $display("ERROR csr_readback: expected %h actual %h (addr %0d)",
                           exp_rd, csr_rdata, csr_addr);
                  csr_errors++;
               end
            end
         end

         // Input side
         if (pix_valid && !pv_q) begin
            if (line_cnt >= 3 && m_enable) queue_row(line_cnt);
            word_cnt = 0;
         end
         if (pix_valid) begin
            mem[line_cnt % 4][word_cnt] = pix_in;
            word_cnt++;
         end
         if (!pix_valid && pv_q) line_cnt++;   // Line done
         pv_q = pix_valid;

         if (csr_we) begin
            case (csr_addr)
               CSR_CTRL: begin
                  m_enable = csr_wdata[0];
                  m_bars   = csr_wdata[1];
               end
               CSR_INVERT: m_invert = csr_wdata[2:0];
               default: ;
            endcase
         end
      end
      pending = exp_q.size();
   end

endmodule

//--- dv/debayer_assert.sv
// Concurrent checks on output valid runs and line buffer rotation, bound into the de-Bayer top
module debayer_assert #(
   parameter int LINE_LENGTH = 640
) (
   input logic       clk,
   input logic       rst,
   input logic       rgb_valid,
   input logic       pix_valid,
   input logic [1:0] wr_sel
);
   timeunit 1ns;
   timeprecision 100ps;

   int run_len;   // Length of the current valid run

   always_ff @(posedge clk) begin
      if (rst || !rgb_valid) begin
         run_len <= 0;
      end else begin
         run_len <= run_len + 1;
      end
   end

   // Output quiet while reset is held
   a_valid_reset: assert property (@(posedge clk) rst |=> !rgb_valid)
      else $error("rgb_valid high during reset");

   // One row is exactly two pixels per input word
   a_row_length: assert property (@(posedge clk) disable iff (rst)
      $fell(rgb_valid) |-> (run_len == 2 * LINE_LENGTH))
      else $error("rgb_valid run of %0d cycles, row length wrong", run_len);

   a_row_overrun: assert property (@(posedge clk) disable iff (rst)
      rgb_valid |-> (run_len < 2 * LINE_LENGTH))
      else $error("rgb_valid run longer than one row");

   // Rotation only one cycle after the last word of a line
   a_rotate: assert property (@(posedge clk) disable iff (rst)
      $changed(wr_sel) |-> (!$past(pix_valid) && $past(pix_valid, 2)))
      else $error("wr_sel changed away from a falling pix_valid");

endmodule

bind debayer_top debayer_assert #(.LINE_LENGTH(LINE_LENGTH)) u_assert (
   .clk       (clk),
   .rst       (rst),
   .rgb_valid (rgb_valid),
   .pix_valid (pix_valid),
   .wr_sel    (wr_sel)
);

//--- hdl/debayer_top.sv
// Top of the de-Bayer path: RAW8 words in, RGB pixels out, control through a small register port
module debayer_top #(
   parameter int LINE_LENGTH = 640   // Words per line
) (
   input  logic               clk,
   input  logic               rst,
   input  isp_pkg::pix_word_t pix_in,
   input  logic               pix_valid,
   input  logic               csr_we,
   input  logic [1:0]         csr_addr,
   input  logic [7:0]         csr_wdata,
   output logic [7:0]         csr_rdata,
   output isp_pkg::rgb_t      rgb_out,
   output logic               rgb_valid
);
   import isp_pkg::*;

   localparam int AW = $clog2(LINE_LENGTH);

   // Line store to interpolator
   logic [AW-1:0]   rd_addr;
   pix_word_t [3:0] rd_word;
   pix_word_t [3:0] rd_next;
   logic [1:0]      wr_sel;

   // Interpolator to output stage
   rgb_t            ip_rgb;
   logic            ip_valid;
   logic            ip_row_end;

   isp_ctrl_t       ctrl;
   logic [7:0]      rows_done;

   line_store #(.LINE_LENGTH(LINE_LENGTH)) u_line_store (
      .clk, .rst,
      .pix_in, .pix_valid,
      .rd_addr, .rd_word, .rd_next,
      .wr_sel
   );

   bayer_interp #(.LINE_LENGTH(LINE_LENGTH)) u_bayer_interp (
      .clk, .rst,
      .ctrl, .pix_valid, .wr_sel,
      .rd_word, .rd_next, .rd_addr,
      .ip_rgb, .ip_valid, .ip_row_end
   );

   isp_csr u_isp_csr (
      .clk, .rst,
      .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
      .ctrl, .rows_done
   );

   rgb_out_stage #(.LINE_LENGTH(LINE_LENGTH)) u_rgb_out_stage (
      .clk, .rst,
      .ctrl, .ip_rgb, .ip_valid, .ip_row_end,
      .rgb_out, .rgb_valid, .rows_done
   );

endmodule

//--- hdl/rgb_out_stage.sv
// Output stage: optional color bars, channel inversion, output register and finished-row count
module rgb_out_stage #(
   parameter int LINE_LENGTH = 640   // Words per line, row is twice this in pixels
) (
   input  logic               clk,
   input  logic               rst,
   input  isp_pkg::isp_ctrl_t ctrl,
   input  isp_pkg::rgb_t      ip_rgb,
   input  logic               ip_valid,
   input  logic               ip_row_end,
   output isp_pkg::rgb_t      rgb_out,
   output logic               rgb_valid,
   output logic [7:0]         rows_done    // Wraps at 256
);
   import isp_pkg::*;

   localparam int CW = $clog2(2 * LINE_LENGTH);

   logic [CW-1:0] col;       // Pixel column within the row
   logic [CW+2:0] col_x8;    // col * 8
   logic [2:0]    bar;       // Bar number 0..7
   rgb_t          bar_pix;
   rgb_t          pix;       // Before inversion

   //----------------------------------------------------------
   // Color bars
   //----------------------------------------------------------

   assign col_x8 = {col, 3'b000};
   assign bar    = 3'(col_x8 / (2 * LINE_LENGTH));

   assign bar_pix.red   = {8{bar[2]}};
   assign bar_pix.green = {8{bar[1]}};
   assign bar_pix.blue  = {8{bar[0]}};

   assign pix = ctrl.bars ? bar_pix : ip_rgb;

   always_ff @(posedge clk) begin
      if (rst) begin
         col       <= '0;
         rgb_valid <= 1'b0;
         rows_done <= '0;
      end else begin
         rgb_valid <= ip_valid;
         if (ip_valid) begin
            col <= ip_row_end ? '0 : CW'(col + 1'b1);
            if (ip_row_end) begin
               rows_done <= 8'(rows_done + 8'd1);
            end
         end
      end
   end

   // Inversion after the bar mux
   always_ff @(posedge clk) begin
      rgb_out.red   <= pix.red   ^ {8{ctrl.invert[2]}};
      rgb_out.green <= pix.green ^ {8{ctrl.invert[1]}};
      rgb_out.blue  <= pix.blue  ^ {8{ctrl.invert[0]}};
   end

endmodule

//--- hdl/isp_csr.sv
// Control registers of the de-Bayer path: enable, inversion mask, color bars, row count readback
module isp_csr (
   input  logic               clk,
   input  logic               rst,
   input  logic               csr_we,      // Write strobe
   input  logic [1:0]         csr_addr,
   input  logic [7:0]         csr_wdata,
   output logic [7:0]         csr_rdata,   // Combinational readback
   output isp_pkg::isp_ctrl_t ctrl,
   input  logic [7:0]         rows_done    // From the output stage
);
   import isp_pkg::*;

   //----------------------------------------------------------
   // Register writes
   //----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.enable <= 1'b1;           // Running out of reset
         ctrl.invert <= INVERT_RESET;   // Board default
         ctrl.bars   <= 1'b0;
      end else if (csr_we) begin
         case (csr_addr)
            CSR_CTRL: begin
               ctrl.enable <= csr_wdata[CTRL_EN_BIT];
               ctrl.bars   <= csr_wdata[CTRL_BARS_BIT];
            end
            CSR_INVERT: begin
               ctrl.invert <= csr_wdata[2:0];
            end
            default: begin
               // ROWS is read only
            end
         endcase
      end
   end

   //----------------------------------------------------------
   // Readback
   //----------------------------------------------------------

   always_comb begin
      csr_rdata = '0;
      case (csr_addr)
         CSR_CTRL: begin
            csr_rdata[CTRL_EN_BIT]   = ctrl.enable;
            csr_rdata[CTRL_BARS_BIT] = ctrl.bars;
         end
         CSR_INVERT: csr_rdata[2:0] = ctrl.invert;
         CSR_ROWS:   csr_rdata      = rows_done;
         default:    csr_rdata      = '0;   // Unmapped
      endcase
   end

endmodule

//--- hdl/bayer_interp.sv
// Bayer interpolator: walks three stored lines per input line and emits two RGB pixels per word
module bayer_interp #(
   parameter int LINE_LENGTH = 640   // Words per line
) (
   input  logic                           clk,
   input  logic                           rst,
   input  isp_pkg::isp_ctrl_t             ctrl,
   input  logic                           pix_valid,
   input  logic [1:0]                     wr_sel,
   input  isp_pkg::pix_word_t [3:0]       rd_word,
   input  isp_pkg::pix_word_t [3:0]       rd_next,
   output logic [$clog2(LINE_LENGTH)-1:0] rd_addr,
   output isp_pkg::rgb_t                  ip_rgb,
   output logic                           ip_valid,
   output logic                           ip_row_end   // Last pixel of the row
);
   import isp_pkg::*;

   localparam int AW = $clog2(LINE_LENGTH);
   typedef logic [AW-1:0] addr_t;

   logic       pv_q;         // pix_valid delayed
   logic       line_start;   // Rising edge of pix_valid
   logic [1:0] lines_seen;   // Saturates at 3 lines stored
   logic       reading;      // Row in progress
   logic       phase;        // 0 first pixel, 1 second pixel
   logic       last_pix;     // Second pixel of last column
   logic [1:0] row_sel;      // wr_sel latched at row start

   // Sample stage, aligned with the line store read data
   logic       s_valid;
   logic       s_phase;
   logic       s_last;

   logic       center_odd;   // Center line is an R G row
   pix_word_t  ua, ub;       // Above line, columns w and w+1
   pix_word_t  ca, cb;       // Center line
   pix_word_t  da, db;       // Below line

   // Halve each term first, then add
   function automatic logic [7:0] half2(input logic [7:0] x, input logic [7:0] y);
      return (x >> 1) + (y >> 1);
   endfunction

   function automatic logic [7:0] quarter4(input logic [7:0] w, input logic [7:0] x,
                                           input logic [7:0] y, input logic [7:0] z);
      return (w >> 2) + (x >> 2) + (y >> 2) + (z >> 2);
   endfunction

   //----------------------------------------------------------
   // Word sequencing
   //----------------------------------------------------------

   assign line_start = pix_valid & ~pv_q;
   assign last_pix   = phase & (rd_addr == addr_t'(LINE_LENGTH - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         pv_q       <= 1'b0;
         lines_seen <= '0;
         reading    <= 1'b0;
         phase      <= 1'b0;
         rd_addr    <= '0;
         row_sel    <= '0;
      end else begin
         pv_q <= pix_valid;
         if (line_start) begin
            if (lines_seen != 2'd3) begin
               lines_seen <= 2'(lines_seen + 2'd1);   // Still filling the store
            end else if (ctrl.enable) begin
               reading <= 1'b1;
               rd_addr <= '0;
               phase   <= 1'b0;
               row_sel <= wr_sel;   // Buffer being written now
            end
         end else if (reading) begin
            phase <= ~phase;
            if (last_pix) begin
               reading <= 1'b0;
            end else if (phase) begin
               rd_addr <= addr_t'(rd_addr + addr_t'(1));   // Next word after both pixels
            end
         end
      end
   end

   //----------------------------------------------------------
   // Pipeline control
   //----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         s_valid    <= 1'b0;
         s_phase    <= 1'b0;
         s_last     <= 1'b0;
         ip_valid   <= 1'b0;
         ip_row_end <= 1'b0;
      end else begin
         s_valid    <= reading;
         s_phase    <= phase;
         s_last     <= reading & last_pix;
         ip_valid   <= s_valid;
         ip_row_end <= s_valid & s_last;
      end
   end

   //----------------------------------------------------------
   // Neighbor mapping and arithmetic
   //----------------------------------------------------------

   // Newest buffer is being written; k-3, k-2, k-1 follow it modulo 4
   assign ua = rd_word[2'(row_sel + 2'd1)];
   assign ub = rd_next[2'(row_sel + 2'd1)];
   assign ca = rd_word[2'(row_sel + 2'd2)];
   assign cb = rd_next[2'(row_sel + 2'd2)];
   assign da = rd_word[2'(row_sel + 2'd3)];
   assign db = rd_next[2'(row_sel + 2'd3)];

   assign center_odd = row_sel[0];   // Same parity as line k-2

   always_ff @(posedge clk) begin
      if (s_valid) begin
         unique case ({center_odd, s_phase})
            2'b10: begin   // R G row, red site
               ip_rgb.red   <= ca.first;
               ip_rgb.green <= quarter4(ub.first, ca.second, cb.second, db.first);
               ip_rgb.blue  <= quarter4(ua.second, ub.second, da.second, db.second);
            end
            2'b11: begin   // R G row, green site
               ip_rgb.red   <= half2(ca.first, cb.first);
               ip_rgb.green <= ca.second;
               ip_rgb.blue  <= half2(ua.second, da.second);
            end
            2'b00: begin   // G B row, green site
               ip_rgb.red   <= half2(ua.first, da.first);
               ip_rgb.green <= ca.first;
               ip_rgb.blue  <= half2(ca.second, cb.second);
            end
            2'b01: begin   // G B row, blue site
               ip_rgb.red   <= quarter4(ua.first, ub.first, da.first, db.first);
               ip_rgb.green <= quarter4(ca.first, cb.first, ua.second, da.second);
               ip_rgb.blue  <= ca.second;
            end
         endcase
      end
   end

endmodule

//--- hdl/line_store.sv
// Four rotating line buffers: the input stream writes one, bayer_interp reads two columns of all four
module line_store #(
   parameter int LINE_LENGTH = 640   // Words per line
) (
   input  logic                           clk,
   input  logic                           rst,
   input  isp_pkg::pix_word_t             pix_in,
   input  logic                           pix_valid,
   input  logic [$clog2(LINE_LENGTH)-1:0] rd_addr,
   output isp_pkg::pix_word_t [3:0]       rd_word,   // Column rd_addr, per buffer
   output isp_pkg::pix_word_t [3:0]       rd_next,   // Column rd_addr+1, clamped
   output logic [1:0]                     wr_sel     // Buffer of the newest line
);
   import isp_pkg::*;

   localparam int AW = $clog2(LINE_LENGTH);
   typedef logic [AW-1:0] addr_t;

   addr_t wr_cnt;      // Word position inside the current line
   addr_t next_addr;   // Right neighbor column
   logic  pv_q;        // pix_valid, one cycle late
   logic  line_done;   // Falling edge of pix_valid

   //----------------------------------------------------------
   // Write side
   //----------------------------------------------------------

   assign line_done = pv_q & ~pix_valid;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_cnt <= '0;
         wr_sel <= '0;
         pv_q   <= 1'b0;
      end else begin
         pv_q <= pix_valid;
         if (line_done) begin
            // Line finished, rotate to the next buffer
            wr_cnt <= '0;
            wr_sel <= 2'(wr_sel + 2'd1);
         end else if (pix_valid) begin
            wr_cnt <= addr_t'(wr_cnt + addr_t'(1));
         end
      end
   end

   //----------------------------------------------------------
   // Read side
   //----------------------------------------------------------

   // Last column has no right neighbor, reuse itself
   assign next_addr = (rd_addr == addr_t'(LINE_LENGTH - 1)) ? rd_addr
                                                            : addr_t'(rd_addr + addr_t'(1));

   for (genvar i = 0; i < 4; i++) begin : g_buf
      pix_word_t mem [LINE_LENGTH];   // One line, block RAM style
      pix_word_t q_word;
      pix_word_t q_next;

      always_ff @(posedge clk) begin
         if (pix_valid && (wr_sel == 2'(i))) begin
            mem[wr_cnt] <= pix_in;   // Write in the cycle of the word
         end
         q_word <= mem[rd_addr];     // Registered reads
         q_next <= mem[next_addr];
      end

      assign rd_word[i] = q_word;
      assign rd_next[i] = q_next;
   end

endmodule

//--- hdl/isp_pkg.sv
// Shared stream types, control struct and register map of the de-Bayer path; import where needed
package isp_pkg;

   //----------------------------------------------------------
   // Stream types
   //----------------------------------------------------------

   // One RAW8 input word, two samples per clock
   typedef struct packed {
      logic [7:0] first;    // Earlier pixel, upper byte
      logic [7:0] second;   // Later pixel, lower byte
   } pix_word_t;

   // One output pixel, 24 bits
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   //----------------------------------------------------------
   // Control
   //----------------------------------------------------------

   // Driven by isp_csr, read by the interpolator and output stage
   typedef struct packed {
      logic       enable;   // Allow new rows to start
      logic [2:0] invert;   // Bit 2 red, bit 1 green, bit 0 blue
      logic       bars;     // Replace picture with color bars
   } isp_ctrl_t;

   // Register map, 2-bit word addresses
   //   CTRL    bit 0 enable, bit 1 bars
   //   INVERT  bits 2:0 red/green/blue invert
   //   ROWS    read only, finished rows modulo 256
   localparam logic [1:0] CSR_CTRL   = 2'd0;
   localparam logic [1:0] CSR_INVERT = 2'd1;
   localparam logic [1:0] CSR_ROWS   = 2'd2;

   // Bit positions inside CSR_CTRL
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_BARS_BIT = 1;

   // Board default, red and green come out of the sensor inverted
   localparam logic [2:0] INVERT_RESET = 3'b110;

endpackage
